// ==== loader_consts.svh ====
// Width, index code, high byte delay and reset value macros for the ROM loader

`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// Bus widths
`define DL_ADDR_W       27          // Download word address from the firmware
`define ROM_ADDR_W      25          // Byte address seen by the ROM side
`define DL_INDEX_W      8
`define CORE_MOD_W      7

// Clocks between the low and the high byte strobe of one wide write
`define DL_HALF_GAP     24

// Download index codes
`define IDX_ROM         8'd0
`define IDX_CORE_MOD    8'd1
`define IDX_DIP         8'd254

// DIP switch bank size
`define DIP_BYTES       4

// Reset values
`define CORE_MOD_RESET  7'd1
`define DIP_RESET       {(`DIP_BYTES*8){1'b1}}   // All switches off

`endif

// ==== loader_dl_pkg.sv ====
// Download stream types: wide firmware word, byte write and the data union

`default_nettype none

`include "loader_consts.svh"

package loader_dl_pkg;

    // Download data is written as one word and consumed as two bytes
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;         // Odd address
            logic [7:0] lo;         // Even address
        } bytes;
    } dl_data_u;

    // One write from the firmware side
    typedef struct packed {
        logic                   wr;
        logic [`DL_ADDR_W-1:0]  addr;
        dl_data_u               data;
        logic [`DL_INDEX_W-1:0] index;
    } dl_word_t;

    // One byte write after the splitter
    typedef struct packed {
        logic                   wr;
        logic [`ROM_ADDR_W-1:0] addr;
        logic [7:0]             data;
        logic [`DL_INDEX_W-1:0] index;
    } dl_byte_t;

endpackage

`default_nettype wire

// ==== loader_cfg_pkg.sv ====
// Configuration types: core mode register and the DIP switch word

`default_nettype none

`include "loader_consts.svh"

package loader_cfg_pkg;

    // Core mode bits, loaded through index 1
    typedef logic [`CORE_MOD_W-1:0] core_mod_t;

    // One DIP switch byte
    typedef logic [7:0] dip_byte_t;

    // DIP bytes packed into one word
    // Element 0 sits in the least significant byte
    typedef dip_byte_t [`DIP_BYTES-1:0] dip_word_t;

endpackage

`default_nettype wire

// ==== dl_byte_splitter.sv ====
// Wide download word to two timed byte writes

`default_nettype none

`include "loader_consts.svh"

module dl_byte_splitter (
    input  wire                      clk_rom,
    input  wire                      rst,
    input  wire loader_dl_pkg::dl_word_t dl_in,
    output loader_dl_pkg::dl_byte_t  byte_wr
);
    import loader_dl_pkg::*;

    localparam int GAP = `DL_HALF_GAP;
    localparam logic [GAP-1:0] GAP_START = GAP'(1);

    logic [GAP-1:0]             gap_sr;     // One-hot delay to the high byte
    logic                       half_wr;
    logic                       half_hi;    // Current strobe is the odd byte
    logic [`DL_INDEX_W-1:0]     index_q;

    dl_data_u                   word_q;
    logic [`ROM_ADDR_W-1:1]     addr_q;     // Byte select bit comes from half_hi

    // Strobe sequencing
    // A new wide write restarts the delay, so a pending high byte is dropped
    always_ff @(posedge clk_rom, posedge rst) begin
        if (rst) begin
            gap_sr  <= '0;
            half_wr <= 1'b0;
            half_hi <= 1'b0;
            index_q <= '1;      // Not a ROM index, keeps downloading low
        end else begin
            if (dl_in.wr) begin
                gap_sr  <= GAP_START;
                half_wr <= 1'b1;            // Low byte goes out right away
                half_hi <= 1'b0;
                index_q <= dl_in.index;
            end else begin
                gap_sr  <= gap_sr << 1;
                half_wr <= gap_sr[GAP-1];   // Last stage fires the high byte
                if (gap_sr[GAP-1]) begin
                    half_hi <= 1'b1;
                end
            end
        end
    end

    // Word payload, held until the next wide write
    always_ff @(posedge clk_rom) begin
        if (dl_in.wr) begin
            word_q.word <= dl_in.data.word;
            addr_q      <= dl_in.addr[`ROM_ADDR_W-1:1];
        end
    end

    always_comb begin
        byte_wr.wr    = half_wr;
        byte_wr.addr  = {addr_q, half_hi};
        byte_wr.data  = half_hi ? word_q.bytes.hi : word_q.bytes.lo;
        byte_wr.index = index_q;
    end

endmodule

`default_nettype wire

// ==== dl_target_decode.sv ====
// Download index decoder: ROM byte write, core mode register, DIP strobe and LED

`default_nettype none

`include "loader_consts.svh"

module dl_target_decode (
    input  wire                          clk_rom,
    input  wire                          rst,
    input  wire loader_dl_pkg::dl_byte_t byte_wr,
    input  wire                          ioctl_download,
    input  wire                          dwnld_busy,
    output loader_dl_pkg::dl_byte_t      rom_byte,
    output loader_dl_pkg::dl_byte_t      dip_wr,
    output logic                         downloading,
    output logic                         led,
    output loader_cfg_pkg::core_mod_t    core_mod
);

    localparam int DIP_SEL_W = $clog2(`DIP_BYTES);

    logic is_rom;
    logic is_core;
    logic is_dip;
    logic dip_in_range;

    // Index held by the splitter between the two halves
    assign is_rom  = byte_wr.index == `IDX_ROM;
    assign is_core = byte_wr.index == `IDX_CORE_MOD;
    assign is_dip  = byte_wr.index == `IDX_DIP;

    // Only the first DIP_BYTES addresses map onto switches
    assign dip_in_range = byte_wr.addr[`ROM_ADDR_W-1:DIP_SEL_W] == '0;

    // Follows the index even between strobes
    assign downloading = ioctl_download && is_rom;
    assign led         = downloading || dwnld_busy;   // Activity LED

    // ROM side byte write
    always_comb begin
        rom_byte    = byte_wr;
        rom_byte.wr = byte_wr.wr && is_rom;
    end

    // DIP bank write
    always_comb begin
        dip_wr    = byte_wr;
        dip_wr.wr = byte_wr.wr && is_dip && dip_in_range;
    end

    // Core mode register
    // Odd address skipped, else the high byte would clobber the low one
    always_ff @(posedge clk_rom, posedge rst) begin
        if (rst) begin
            core_mod <= `CORE_MOD_RESET;
        end else begin
            if (byte_wr.wr && is_core && !byte_wr.addr[0]) begin
                core_mod <= byte_wr.data[`CORE_MOD_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== dip_switch_bank.sv ====
// DIP switch byte registers presented as one 32-bit word

`default_nettype none

`include "loader_consts.svh"

module dip_switch_bank (
    input  wire                          clk_rom,
    input  wire                          rst,
    input  wire loader_dl_pkg::dl_byte_t dip_wr,
    output loader_cfg_pkg::dip_word_t    dipsw
);
    import loader_cfg_pkg::*;

    localparam int DIP_SEL_W = $clog2(`DIP_BYTES);

    dip_word_t              dip_q;
    logic [DIP_SEL_W-1:0]   dip_sel;

    // Range already checked upstream
    assign dip_sel = dip_wr.addr[DIP_SEL_W-1:0];

    always_ff @(posedge clk_rom, posedge rst) begin
        if (rst) begin
            dip_q <= `DIP_RESET;    // All ones until the download fills them
        end else begin
            if (dip_wr.wr) begin
                dip_q[dip_sel] <= dip_wr.data;
            end
        end
    end

    assign dipsw = dip_q;   // Byte n at bits 8n+7:8n

endmodule

`default_nettype wire

// ==== rom_loader_top.sv ====
// ROM download path top: byte splitter, index decoder and DIP switch bank

`default_nettype none

module rom_loader_top (
    input  wire                          clk_rom,
    input  wire                          rst,
    input  wire loader_dl_pkg::dl_word_t dl_in,
    input  wire                          ioctl_download,
    input  wire                          dwnld_busy,
    output loader_dl_pkg::dl_byte_t      rom_byte,
    output logic                         downloading,
    output logic                         led,
    output loader_cfg_pkg::core_mod_t    core_mod,
    output loader_cfg_pkg::dip_word_t    dipsw
);
    import loader_dl_pkg::*;

    dl_byte_t byte_wr;      // Splitter to decoder
    dl_byte_t dip_wr;       // Decoder to DIP bank

    // 16-bit firmware words to byte writes
    dl_byte_splitter u_splitter (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .dl_in          ( dl_in          ),
        .byte_wr        ( byte_wr        )
    );

    dl_target_decode u_decode (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .byte_wr        ( byte_wr        ),
        .ioctl_download ( ioctl_download ),
        .dwnld_busy     ( dwnld_busy     ),
        .rom_byte       ( rom_byte       ),
        .dip_wr         ( dip_wr         ),
        .downloading    ( downloading    ),
        .led            ( led            ),
        .core_mod       ( core_mod       )
    );

    // Index 254 target
    dip_switch_bank u_dip (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .dip_wr         ( dip_wr         ),
        .dipsw          ( dipsw          )
    );

endmodule

`default_nettype wire

// ==== tb_loader_checker.sv ====
// Testbench checker: models the ROM loader rules and compares the DUT ports

`default_nettype none

`include "loader_consts.svh"

module tb_loader_checker (
    input  wire                            clk_rom,
    input  wire                            rst,
    input  wire loader_dl_pkg::dl_word_t   dl_in,
    input  wire                            ioctl_download,
    input  wire                            dwnld_busy,
    input  wire loader_dl_pkg::dl_byte_t   rom_byte,
    input  wire                            downloading,
    input  wire                            led,
    input  wire loader_cfg_pkg::core_mod_t core_mod,
    input  wire loader_cfg_pkg::dip_word_t dipsw,
    output int                             tests_done,
    output int                             checks,
    output int                             errors
);
    import loader_dl_pkg::*;
    import loader_cfg_pkg::*;

    localparam int RST_TIMEOUT   = 64;
    localparam int WRITE_TIMEOUT = 64;
    localparam int ENTRY_CLOCKS  = `DL_HALF_GAP + 4;    // Past the high byte and its update

    logic      held_rom;        // Last wide write carried the ROM index
    core_mod_t exp_core;
    dip_word_t exp_dip;

    task automatic check_val(
        input string       name,
        input logic [31:0] exp,
        input logic [31:0] act
    );
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // One clock sampled on the falling edge
    task automatic tick();
        logic exp_dl;
        @(negedge clk_rom);
        if (!rst) begin
            exp_dl = ioctl_download && held_rom;
            check_val("downloading", 32'(exp_dl), 32'(downloading));
            check_val("led", 32'(exp_dl || dwnld_busy), 32'(led));
        end
        // Splitter takes the index on the next rising edge
        if (rst) begin
            held_rom = 1'b0;
        end else if (dl_in.wr) begin
            held_rom = dl_in.index == `IDX_ROM;
        end
    endtask

    task automatic wait_for_write(output logic found, output dl_word_t w);
        int n;
        found = 1'b0;
        w     = '0;
        n     = 0;
        while (!found && n < WRITE_TIMEOUT) begin
            tick();
            check_val("rom_byte.wr", 32'd0, 32'(rom_byte.wr));  // Idle bus
            if (dl_in.wr) begin
                found = 1'b1;
                w     = dl_in;
            end
            n++;
        end
    endtask

    task automatic check_rom_strobe(
        input logic [`ROM_ADDR_W-1:0] addr,
        input logic [7:0]             data
    );
        check_val("rom_byte.addr", 32'(addr), 32'(rom_byte.addr));
        check_val("rom_byte.data", 32'(data), 32'(rom_byte.data));
        check_val("rom_byte.index", 32'(`IDX_ROM), 32'(rom_byte.index));
    endtask

    task automatic check_entry(input dl_word_t w);
        logic [`ROM_ADDR_W-1:0] lo_addr;
        logic [`ROM_ADDR_W-1:0] hi_addr;
        logic [7:0]             lo_data;
        logic [7:0]             hi_data;
        logic                   rom_idx;
        logic                   lo_seen;
        logic                   hi_seen;
        int                     k;
        int                     err_before;
        err_before = errors;
        lo_addr    = {w.addr[`ROM_ADDR_W-1:1], 1'b0};   // Upper word address bits dropped
        hi_addr    = {w.addr[`ROM_ADDR_W-1:1], 1'b1};
        lo_data    = w.data.word[7:0];
        hi_data    = w.data.word[15:8];
        rom_idx    = w.index == `IDX_ROM;
        lo_seen    = 1'b0;
        hi_seen    = 1'b0;
        for (k = 1; k <= ENTRY_CLOCKS; k++) begin
            tick();
            if (rom_idx && k == 1 && rom_byte.wr) begin
                lo_seen = 1'b1;
                check_rom_strobe(lo_addr, lo_data);
            end else if (rom_idx && k == 1 + `DL_HALF_GAP && rom_byte.wr) begin
                hi_seen = 1'b1;
                check_rom_strobe(hi_addr, hi_data);
            end else if (!(rom_idx && (k == 1 || k == 1 + `DL_HALF_GAP))) begin
                check_val("rom_byte.wr", 32'd0, 32'(rom_byte.wr));
            end
        end
        if (rom_idx && !lo_seen) begin
            errors++;
            $display("timeout: entry %0d never produced its low byte ROM write", tests_done);
        end
        if (rom_idx && !hi_seen) begin
            errors++;
            $display("timeout: entry %0d never produced its high byte ROM write", tests_done);
        end

        // Register targets
        if (w.index == `IDX_CORE_MOD) begin
            exp_core = lo_data[`CORE_MOD_W-1:0];    // Odd byte ignored
        end
        if (w.index == `IDX_DIP) begin
            if (int'(lo_addr) < `DIP_BYTES) begin
                exp_dip[lo_addr[1:0]] = lo_data;
            end
            if (int'(hi_addr) < `DIP_BYTES) begin
                exp_dip[hi_addr[1:0]] = hi_data;
            end
        end
        check_val("core_mod", 32'(exp_core), 32'(core_mod));
        check_val("dipsw", exp_dip, dipsw);

        if (errors == err_before) begin
            $display("entry %0d index %0d addr %h data %h: ok",
                     tests_done, w.index, w.addr, w.data.word);
        end else begin
            $display("entry %0d index %0d addr %h data %h: %0d errors",
                     tests_done, w.index, w.addr, w.data.word, errors - err_before);
        end
        tests_done++;
    endtask

    initial begin
        dl_word_t w;
        logic     found;
        int       n;
        int       err_before;
        tests_done = 0;
        checks     = 0;
        errors     = 0;
        held_rom   = 1'b0;
        exp_core   = `CORE_MOD_RESET;
        exp_dip    = `DIP_RESET;
        n          = 0;
        tick();
        while (rst && n < RST_TIMEOUT) begin
            tick();
            n++;
        end
        if (rst) begin
            errors++;
            $display("timeout: reset was never released");
        end else begin
            err_before = errors;
            check_val("rom_byte.wr", 32'd0, 32'(rom_byte.wr));
            check_val("core_mod", 32'(exp_core), 32'(core_mod));
            check_val("dipsw", exp_dip, dipsw);
            check_val("downloading", 32'd0, 32'(downloading));
            $display("reset values: %s", (errors == err_before) ? "ok" : "wrong");
        end
        forever begin
            wait_for_write(found, w);
            if (found) begin
                check_entry(w);
            end else begin
                errors++;
                $display("timeout: no download write seen within %0d clocks", WRITE_TIMEOUT);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_rom_loader.sv ====
// Testbench top: clock, reset, LFSR data source, stimulus table loop and the DUT

`default_nettype none

`include "loader_consts.svh"

module tb_rom_loader;
    import loader_dl_pkg::*;
    import loader_cfg_pkg::*;

    localparam int          N_ENTRIES     = 11;
    localparam int          WRITE_SPACING = 32;     // Clocks between wide writes
    localparam int          RST_CYCLES    = 16;
    localparam int          DONE_TIMEOUT  = 100;
    localparam logic [31:0] LFSR_SEED     = 32'h073e_1ed5;

    // One table row
    typedef struct packed {
        logic [`DL_INDEX_W-1:0] index;
        logic [`DL_ADDR_W-1:0]  addr;       // Word address as the firmware gives it
        logic                   dl;         // ioctl_download level
        logic                   busy;       // dwnld_busy level
        logic                   rnd;        // Data from the LFSR
        logic [15:0]            data;
    } stim_t;

    logic        clk_rom = 1'b0;
    logic        rst;
    dl_word_t    dl_in;
    logic        ioctl_download;
    logic        dwnld_busy;
    dl_byte_t    rom_byte;
    logic        downloading;
    logic        led;
    core_mod_t   core_mod;
    dip_word_t   dipsw;
    logic [31:0] lfsr_state;
    int          tests_done;
    int          checks;
    int          errors;

    stim_t stim_table [N_ENTRIES] = '{
        '{`IDX_ROM,      27'h000_0010, 1'b1, 1'b0, 1'b1, 16'h0000},
        '{`IDX_ROM,      27'h7ff_fff3, 1'b1, 1'b1, 1'b0, 16'hbeef},  // Odd, above 25 bits
        '{`IDX_ROM,      27'h000_0400, 1'b0, 1'b0, 1'b1, 16'h0000},
        '{`IDX_DIP,      27'h000_0000, 1'b1, 1'b0, 1'b0, 16'h3412},
        '{`IDX_DIP,      27'h000_0002, 1'b1, 1'b1, 1'b0, 16'h7856},
        '{`IDX_DIP,      27'h000_0004, 1'b1, 1'b0, 1'b1, 16'h0000},  // Out of range
        '{`IDX_DIP,      27'h000_0100, 1'b0, 1'b1, 1'b1, 16'h0000},
        '{`IDX_CORE_MOD, 27'h000_0000, 1'b1, 1'b0, 1'b0, 16'h55aa},
        '{`IDX_CORE_MOD, 27'h000_0008, 1'b1, 1'b0, 1'b1, 16'h0000},
        '{8'd7,          27'h000_0020, 1'b1, 1'b1, 1'b1, 16'h0000},  // Unused index
        '{`IDX_ROM,      27'h000_1234, 1'b1, 1'b0, 1'b1, 16'h0000}
    };

    always #4 clk_rom = ~clk_rom;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_random_word(output logic [15:0] w);
        int b;
        w = '0;
        for (b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w          = {w[14:0], lfsr_state[0]};   // One step per bit
        end
    endtask

    // One wide write, then idle up to the next slot
    task automatic apply_entry(input stim_t s);
        logic [15:0] data;
        data = s.data;
        if (s.rnd) begin
            draw_random_word(data);
        end
        @(posedge clk_rom);
        dl_in.wr        <= 1'b1;
        dl_in.addr      <= s.addr;
        dl_in.data.word <= data;
        dl_in.index     <= s.index;
        ioctl_download  <= s.dl;
        dwnld_busy      <= s.busy;
        @(posedge clk_rom);
        dl_in.wr <= 1'b0;
        repeat (WRITE_SPACING - 2) @(posedge clk_rom);
    endtask

    rom_loader_top rom_loader_top_inst (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .dl_in          ( dl_in          ),
        .ioctl_download ( ioctl_download ),
        .dwnld_busy     ( dwnld_busy     ),
        .rom_byte       ( rom_byte       ),
        .downloading    ( downloading    ),
        .led            ( led            ),
        .core_mod       ( core_mod       ),
        .dipsw          ( dipsw          )
    );

    tb_loader_checker loader_checker_inst (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .dl_in          ( dl_in          ),
        .ioctl_download ( ioctl_download ),
        .dwnld_busy     ( dwnld_busy     ),
        .rom_byte       ( rom_byte       ),
        .downloading    ( downloading    ),
        .led            ( led            ),
        .core_mod       ( core_mod       ),
        .dipsw          ( dipsw          ),
        .tests_done     ( tests_done     ),
        .checks         ( checks         ),
        .errors         ( errors         )
    );

    initial begin
        int i;
        int n;
        rst            <= 1'b1;
        dl_in          <= '0;
        ioctl_download <= 1'b0;
        dwnld_busy     <= 1'b0;
        lfsr_state      = LFSR_SEED;
        repeat (RST_CYCLES) @(posedge clk_rom);
        rst <= 1'b0;
        repeat (4) @(posedge clk_rom);     // Quiet bus after reset
        for (i = 0; i < N_ENTRIES; i++) begin
            apply_entry(stim_table[i]);
        end
        n = 0;
        while (tests_done < N_ENTRIES && n < DONE_TIMEOUT) begin
            @(posedge clk_rom);
            n++;
        end
        if (tests_done < N_ENTRIES) begin
            $display("timeout: checker finished %0d of %0d table entries",
                     tests_done, N_ENTRIES);
        end
        $display("tests %0d of %0d, checks %0d, errors %0d",
                 tests_done, N_ENTRIES, checks, errors);
        if (tests_done == N_ENTRIES && errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
loader_dl_pkg.sv
loader_cfg_pkg.sv
dl_byte_splitter.sv
dl_target_decode.sv
dip_switch_bank.sv
rom_loader_top.sv
tb_loader_checker.sv
tb_rom_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ROM loader testbench with Verilator

set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_rom_loader \
    -f sim.f \
    -o sim_rom_loader

./obj_dir/sim_rom_loader | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi

echo "Simulation did not pass, see sim.log"
exit 1
